// ==== arm_consts.svh ====
`ifndef ARM_CONSTS_SVH
`define ARM_CONSTS_SVH

// ============================================================
// Instruction class patterns for casez, most specific first
// ============================================================
`define DECODE_ALU_MULT          32'b????_0000_00??_????_????_????_1001_????
`define DECODE_ALU_MRS           32'b????_0001_0?00_1111_????_0000_0000_0000
`define DECODE_ALU_MSR           32'b????_0001_0?10_1001_1111_0000_0000_????
`define DECODE_ALU_MSR_FLAGS     32'b????_00?1_0?10_1000_1111_????_????_????
`define DECODE_ALU_SWP           32'b????_0001_0?00_????_????_0000_1001_????
`define DECODE_ALU_BX            32'b????_0001_0010_1111_1111_1111_0001_????
`define DECODE_ALU_HDATA_REG     32'b????_000?_?0??_????_????_0000_1??1_????
`define DECODE_ALU_HDATA_IMM     32'b????_000?_?1??_????_????_????_1??1_????
`define DECODE_ALU               32'b????_00??_????_????_????_????_????_????
`define DECODE_LDRSTR_UNDEFINED  32'b????_011?_????_????_????_????_???1_????
`define DECODE_LDRSTR            32'b????_01??_????_????_????_????_????_????
`define DECODE_LDMSTM            32'b????_100?_????_????_????_????_????_????
`define DECODE_BRANCH            32'b????_101?_????_????_????_????_????_????
`define DECODE_LDCSTC            32'b????_110?_????_????_????_????_????_????
`define DECODE_CDP               32'b????_1110_????_????_????_????_???0_????
`define DECODE_MRCMCR            32'b????_1110_????_????_????_????_???1_????
`define DECODE_SWI               32'b????_1111_????_????_????_????_????_????

// Data processing opcodes, insn[24:21]
`define ALU_AND 4'b0000
`define ALU_EOR 4'b0001
`define ALU_SUB 4'b0010
`define ALU_RSB 4'b0011
`define ALU_ADD 4'b0100
`define ALU_ADC 4'b0101
`define ALU_SBC 4'b0110
`define ALU_RSC 4'b0111
`define ALU_TST 4'b1000
`define ALU_TEQ 4'b1001
`define ALU_CMP 4'b1010
`define ALU_CMN 4'b1011
`define ALU_ORR 4'b1100
`define ALU_MOV 4'b1101
`define ALU_BIC 4'b1110
`define ALU_MVN 4'b1111

// Barrel shifter types, insn[6:5]
`define SHIFT_LSL 2'b00
`define SHIFT_LSR 2'b01
`define SHIFT_ASR 2'b10
`define SHIFT_ROR 2'b11

// Condition field, insn[31:28]
`define COND_EQ 4'b0000
`define COND_NE 4'b0001
`define COND_CS 4'b0010
`define COND_CC 4'b0011
`define COND_MI 4'b0100
`define COND_PL 4'b0101
`define COND_VS 4'b0110
`define COND_VC 4'b0111
`define COND_HI 4'b1000
`define COND_LS 4'b1001
`define COND_GE 4'b1010
`define COND_LT 4'b1011
`define COND_GT 4'b1100
`define COND_LE 4'b1101
`define COND_AL 4'b1110
`define COND_NV 4'b1111

`define COND_MATTERS(c) ((c) != `COND_AL)

// Flag positions inside the NZCV nibble, and where it sits in the status word
`define FLAG_N 3
`define FLAG_Z 2
`define FLAG_C 1
`define FLAG_V 0
`define STATUS_FLAGS_HI 31
`define STATUS_FLAGS_LO 28

// Stages between issue and writeback
`define ISSUE_INFLIGHT_DEPTH 2

`endif

// ==== arm_isa_pkg.sv ====
`default_nettype none

package arm_isa_pkg;

	// ============================================================
	// Architectural widths
	// ============================================================

	// Instruction, PC or status word
	typedef logic [31:0] word_t;

	// One bit per architectural register r0..r15
	// r15 never takes part in hazard tracking
	typedef logic [15:0] reg_mask_t;

	// Register number as found in the Rn/Rd/Rs/Rm fields
	typedef logic [3:0] reg_idx_t;

	// Condition field of every instruction
	typedef logic [3:0] cond_t;

	// N, Z, C, V packed as one nibble, N on top
	typedef logic [3:0] flags_t;

	// Data processing opcode field
	typedef logic [3:0] alu_op_t;

endpackage

`default_nettype wire

// ==== arm_pipe_pkg.sv ====
`default_nettype none

package arm_pipe_pkg;

	// ============================================================
	// Records passed between the issue stage blocks
	// ============================================================

	// Instruction arriving from decode/fetch
	typedef struct packed {
		logic                bubble;
		arm_isa_pkg::word_t  pc;
		arm_isa_pkg::word_t  insn;
	} stage_in_t;

	// What one instruction reads and writes
	typedef struct packed {
		arm_isa_pkg::reg_mask_t  use_regs;
		arm_isa_pkg::reg_mask_t  def_regs;
		logic                    use_flags;
		logic                    def_flags;
	} usage_t;

	// Write record kept while an instruction is in flight
	typedef struct packed {
		arm_isa_pkg::reg_mask_t  def_regs;
		logic                    def_flags;
	} inflight_t;

	// Instruction handed on to execute
	typedef struct packed {
		logic                bubble;
		arm_isa_pkg::word_t  pc;
		arm_isa_pkg::word_t  insn;
	} stage_out_t;

endpackage

`default_nettype wire

// ==== reg_usage_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "arm_consts.svh"

module reg_usage_decode (
	input  arm_isa_pkg::word_t   insn,
	output arm_pipe_pkg::usage_t usage
);

	import arm_isa_pkg::*;

	// Register fields
	reg_idx_t rn;
	reg_idx_t rd;
	reg_idx_t rs;
	reg_idx_t rm;
	// Multiply swaps the roles of the upper fields
	reg_idx_t rd_mul;
	reg_idx_t rn_mul;
	cond_t    cond;
	alu_op_t  alu_opc;
	logic     cond_reads;

	assign rn      = insn[19:16];
	assign rd      = insn[15:12];
	assign rs      = insn[11:8];
	assign rm      = insn[3:0];
	assign rd_mul  = insn[19:16];
	assign rn_mul  = insn[15:12];
	assign cond    = insn[31:28];
	assign alu_opc = insn[24:21];

	// Any condition except AL has to look at the flags
	assign cond_reads = `COND_MATTERS(cond);

	// Mask bit for a register, r15 gives nothing
	function automatic reg_mask_t reg_bit(input reg_idx_t r);
		if (r == 4'd15)
			return '0;
		return reg_mask_t'(1) << r;
	endfunction

	function automatic logic flags_only(input alu_op_t op);
		return (op == `ALU_TST) || (op == `ALU_TEQ) || (op == `ALU_CMP) || (op == `ALU_CMN);
	endfunction

	// Operand 2 field insn[11:4]: amount [7:3], type [2:1], register shift [0]
	// LSL #0 passes the old carry, ROR #0 is RRX
	function automatic logic shift_needs_carry(input logic [7:0] shift);
		if (shift[0])
			return 1'b0;
		if (shift[7:3] != 5'd0)
			return 1'b0;
		return (shift[2:1] == `SHIFT_LSL) || (shift[2:1] == `SHIFT_ROR);
	endfunction

	// ============================================================
	// Class decode
	// ============================================================
	always_comb
	begin
		usage = '0;
		casez (insn)
			// Must precede ALU, it is a corner of the ALU space
			`DECODE_ALU_MULT:
			begin
				usage.use_flags = cond_reads;
				usage.use_regs  = reg_bit(rs) | reg_bit(rm);
				if (insn[21])
					usage.use_regs |= reg_bit(rn_mul);
				usage.def_flags = insn[20];
				usage.def_regs  = reg_bit(rd_mul);
			end
			`DECODE_ALU_MRS:
			begin
				// Reading CPSR reads the flags
				usage.use_flags = cond_reads | ~insn[22];
				usage.def_regs  = reg_bit(rd);
			end
			`DECODE_ALU_MSR:
			begin
				usage.use_flags = cond_reads;
				usage.use_regs  = reg_bit(rm);
				usage.def_flags = 1'b1;
			end
			`DECODE_ALU_MSR_FLAGS:
			begin
				usage.use_flags = cond_reads;
				usage.use_regs  = insn[25] ? '0 : reg_bit(rm);
				usage.def_flags = 1'b1;
			end
			`DECODE_ALU_SWP:
			begin
				usage.use_flags = cond_reads;
				usage.use_regs  = reg_bit(rn) | reg_bit(rm);
				usage.def_regs  = reg_bit(rd);
			end
			`DECODE_ALU_BX:
			begin
				usage.use_flags = cond_reads;
				usage.use_regs  = reg_bit(rm);
			end
			`DECODE_ALU_HDATA_REG:
			begin
				usage.use_flags = cond_reads;
				usage.use_regs  = reg_bit(rn) | reg_bit(rm) | (insn[20] ? '0 : reg_bit(rd));
				usage.def_regs  = insn[20] ? reg_bit(rd) : '0;
			end
			`DECODE_ALU_HDATA_IMM:
			begin
				usage.use_flags = cond_reads;
				usage.use_regs  = reg_bit(rn) | (insn[20] ? '0 : reg_bit(rd));
				usage.def_regs  = insn[20] ? reg_bit(rd) : '0;
			end
			`DECODE_ALU:
			begin
				usage.use_flags = cond_reads | (~insn[25] & shift_needs_carry(insn[11:4]));
				if (!insn[25])
				begin
					usage.use_regs = reg_bit(rm);
					if (insn[4])
						usage.use_regs |= reg_bit(rs);
				end
				// MOV and MVN have no first operand
				if ((alu_opc != `ALU_MOV) && (alu_opc != `ALU_MVN))
					usage.use_regs |= reg_bit(rn);
				usage.def_flags = insn[20];
				usage.def_regs  = flags_only(alu_opc) ? '0 : reg_bit(rd);
			end
			`DECODE_LDRSTR_UNDEFINED:
			begin
				// Traps, nothing read or written
				usage = '0;
			end
			`DECODE_LDRSTR:
			begin
				usage.use_flags = cond_reads;
				usage.use_regs  = reg_bit(rn) | (insn[25] ? reg_bit(rm) : '0)
					| (insn[20] ? '0 : reg_bit(rd));
				usage.def_regs  = insn[20] ? reg_bit(rd) : '0;
			end
			`DECODE_LDMSTM:
			begin
				usage.use_flags = cond_reads;
				usage.use_regs  = reg_bit(rn) | (insn[20] ? '0 : {1'b0, insn[14:0]});
				// S bit may restore the flags from SPSR
				usage.def_flags = insn[22];
				usage.def_regs  = (insn[21] ? reg_bit(rn) : '0)
					| (insn[20] ? {1'b0, insn[14:0]} : '0);
			end
			`DECODE_BRANCH:
			begin
				usage.use_flags = cond_reads;
				// BL writes the link register
				usage.def_regs  = insn[24] ? reg_bit(4'd14) : '0;
			end
			`DECODE_LDCSTC:
			begin
				usage.use_flags = cond_reads;
				usage.use_regs  = reg_bit(rn);
				usage.def_regs  = insn[21] ? reg_bit(rn) : '0;
			end
			`DECODE_CDP:
			begin
				usage.use_flags = cond_reads;
			end
			`DECODE_MRCMCR:
			begin
				usage.use_flags = cond_reads;
				usage.use_regs  = insn[20] ? '0 : reg_bit(rd);
				usage.def_regs  = insn[20] ? reg_bit(rd) : '0;
			end
			`DECODE_SWI:
			begin
				usage.use_flags = cond_reads;
			end
			default:
			begin
				usage = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== issue_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "arm_consts.svh"

module issue_ctrl (
	input  logic                      clk,
	input  logic                      Nrst,
	input  logic                      stall,
	input  logic                      flush,
	input  arm_pipe_pkg::stage_in_t   in,
	input  arm_isa_pkg::word_t        status,
	input  arm_pipe_pkg::usage_t      usage,
	input  logic                      wait_regs,
	input  logic                      wait_flags,
	output arm_pipe_pkg::stage_out_t  out,
	output logic                      stall_up,
	output logic                      advance,
	output arm_pipe_pkg::inflight_t   new_rec
);

	import arm_isa_pkg::*;

	cond_t  cond;
	flags_t flags;
	logic   cond_met;
	logic   hazard;
	// Instruction must not enter the slot chain
	logic   squash;
	logic   deferred_flush;
	logic   out_bubble;
	word_t  out_pc;
	word_t  out_insn;

	assign cond  = in.insn[31:28];
	assign flags = status[`STATUS_FLAGS_HI:`STATUS_FLAGS_LO];

	// ============================================================
	// Condition evaluation
	// ============================================================
	always_comb
	begin
		case (cond)
			`COND_EQ: cond_met = flags[`FLAG_Z];
			`COND_NE: cond_met = ~flags[`FLAG_Z];
			`COND_CS: cond_met = flags[`FLAG_C];
			`COND_CC: cond_met = ~flags[`FLAG_C];
			`COND_MI: cond_met = flags[`FLAG_N];
			`COND_PL: cond_met = ~flags[`FLAG_N];
			`COND_VS: cond_met = flags[`FLAG_V];
			`COND_VC: cond_met = ~flags[`FLAG_V];
			`COND_HI: cond_met = flags[`FLAG_C] & ~flags[`FLAG_Z];
			`COND_LS: cond_met = ~flags[`FLAG_C] | flags[`FLAG_Z];
			`COND_GE: cond_met = flags[`FLAG_N] == flags[`FLAG_V];
			`COND_LT: cond_met = flags[`FLAG_N] != flags[`FLAG_V];
			`COND_GT: cond_met = ~flags[`FLAG_Z] & (flags[`FLAG_N] == flags[`FLAG_V]);
			`COND_LE: cond_met = flags[`FLAG_Z] | (flags[`FLAG_N] != flags[`FLAG_V]);
			`COND_AL: cond_met = 1'b1;
			// NV never executes
			default:  cond_met = 1'b0;
		endcase
	end

	// ============================================================
	// Stall and slot feed
	// ============================================================
	assign hazard   = wait_regs | wait_flags;
	// A bubble or a flushed instruction has nothing to wait for
	assign stall_up = stall | (hazard & ~in.bubble & ~flush);
	assign advance  = ~stall;
	assign squash   = in.bubble | hazard | ~cond_met;

	always_comb
	begin
		new_rec = '0;
		if (!squash)
		begin
			new_rec.def_regs  = usage.def_regs;
			new_rec.def_flags = usage.def_flags;
		end
	end

	// Flush that arrives while the stage is held is applied to the next accepted insn
	always_ff @(posedge clk or negedge Nrst)
	begin
		if (!Nrst)
			deferred_flush <= 1'b0;
		else if (flush && stall_up)
			deferred_flush <= 1'b1;
		else if (!stall_up)
			deferred_flush <= 1'b0;
	end

	// ============================================================
	// Output register
	// ============================================================
	always_ff @(posedge clk or negedge Nrst)
	begin
		if (!Nrst)
			out_bubble <= 1'b1;
		else if (advance)
			out_bubble <= squash | flush | deferred_flush;
	end

	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			out_pc   <= in.pc;
			out_insn <= in.insn;
		end
	end

	assign out = '{bubble: out_bubble, pc: out_pc, insn: out_insn};

endmodule

`default_nettype wire

// ==== inflight_slot.sv ====
`timescale 1ns/1ps
`default_nettype none

module inflight_slot (
	input  logic                     clk,
	input  logic                     Nrst,
	input  logic                     advance,
	input  arm_pipe_pkg::inflight_t  rec_in,
	output arm_pipe_pkg::inflight_t  rec_out
);

	// One pipeline step of pending register and flag writes
	// An empty record means the stage holds a bubble or a squashed insn
	always_ff @(posedge clk or negedge Nrst)
	begin
		if (!Nrst)
		begin
			rec_out <= '0;
		end
		else if (advance)
		begin
			rec_out <= rec_in;
		end
	end

endmodule

`default_nettype wire

// ==== hazard_detect.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "arm_consts.svh"

module hazard_detect #(
	parameter int DEPTH = `ISSUE_INFLIGHT_DEPTH
) (
	input  arm_pipe_pkg::usage_t     usage,
	input  arm_pipe_pkg::inflight_t  slots [0:DEPTH-1],
	output logic                     wait_regs,
	output logic                     wait_flags,
	output arm_pipe_pkg::inflight_t  retire
);

	import arm_isa_pkg::*;

	// Everything written by instructions not yet at writeback
	reg_mask_t busy_regs;
	logic      busy_flags;

	always_comb
	begin
		busy_regs  = '0;
		busy_flags = 1'b0;
		for (int k = 0; k < DEPTH; k++)
		begin
			busy_regs  = busy_regs | slots[k].def_regs;
			busy_flags = busy_flags | slots[k].def_flags;
		end
	end

	assign wait_regs  = |(usage.use_regs & busy_regs);
	assign wait_flags = usage.use_flags & busy_flags;

	// Oldest record leaves the chain on the next advance
	assign retire = slots[DEPTH-1];

endmodule

`default_nettype wire

// ==== arm_issue_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "arm_consts.svh"

module arm_issue_top #(
	parameter int DEPTH = `ISSUE_INFLIGHT_DEPTH
) (
	input  logic                      clk,
	input  logic                      Nrst,
	input  logic                      stall,
	input  logic                      flush,
	input  arm_pipe_pkg::stage_in_t   in,
	input  arm_isa_pkg::word_t        status,
	output arm_pipe_pkg::stage_out_t  out,
	output logic                      stall_up,
	output arm_pipe_pkg::inflight_t   retire
);

	import arm_pipe_pkg::*;

	usage_t    usage;
	logic      wait_regs;
	logic      wait_flags;
	logic      advance;
	inflight_t new_rec;
	inflight_t slot_rec [0:DEPTH-1];

	reg_usage_decode decode_i (
		.insn  (in.insn),
		.usage (usage)
	);

	issue_ctrl ctrl_i (
		.clk        (clk),
		.Nrst       (Nrst),
		.stall      (stall),
		.flush      (flush),
		.in         (in),
		.status     (status),
		.usage      (usage),
		.wait_regs  (wait_regs),
		.wait_flags (wait_flags),
		.out        (out),
		.stall_up   (stall_up),
		.advance    (advance),
		.new_rec    (new_rec)
	);

	// ============================================================
	// In-flight chain, slot 0 is the youngest
	// ============================================================
	for (genvar k = 0; k < DEPTH; k++)
	begin : g_slot
		inflight_t rec_in;

		if (k == 0)
		begin : g_head
			assign rec_in = new_rec;
		end
		else
		begin : g_link
			assign rec_in = slot_rec[k-1];
		end

		inflight_slot slot_i (
			.clk     (clk),
			.Nrst    (Nrst),
			.advance (advance),
			.rec_in  (rec_in),
			.rec_out (slot_rec[k])
		);
	end

	hazard_detect #(
		.DEPTH (DEPTH)
	) hazard_i (
		.usage      (usage),
		.slots      (slot_rec),
		.wait_regs  (wait_regs),
		.wait_flags (wait_flags),
		.retire     (retire)
	);

endmodule

`default_nettype wire

// ==== tb_issue_model.svh ====
`ifndef TB_ISSUE_MODEL_SVH
`define TB_ISSUE_MODEL_SVH

// ============================================================
// Issue stage reference model, lives inside the testbench module
// ============================================================

// State as it stands after the most recent clock edge
inflight_t m_slot [0:DEPTH-1];
logic      m_bubble;
word_t     m_pc;
word_t     m_insn;
logic      m_deferred;

function automatic reg_mask_t mask_of(input logic [3:0] r);
	reg_mask_t m;
	m = '0;
	// r15 is never tracked
	if (r != 4'd15)
		m[r] = 1'b1;
	return m;
endfunction

// Registers and flags read and written by one instruction
function automatic usage_t expected_usage(input word_t i);
	usage_t u;
	reg_mask_t list;
	u = '0;
	list = {1'b0, i[14:0]};
	u.use_flags = (i[31:28] != 4'hE);
	if (i[27:22] == 6'b000000 && i[7:4] == 4'b1001)
	begin
		// Multiply, destination in [19:16], accumulator in [15:12]
		u.use_regs = mask_of(i[11:8]) | mask_of(i[3:0]) | (i[21] ? mask_of(i[15:12]) : '0);
		u.def_regs = mask_of(i[19:16]);
		u.def_flags = i[20];
	end
	else if (i[27:23] == 5'b00010 && i[21:16] == 6'b001111 && i[11:0] == 12'h000)
	begin
		// MRS of CPSR reads the flags
		u.use_flags = u.use_flags | !i[22];
		u.def_regs = mask_of(i[15:12]);
	end
	else if (i[27:23] == 5'b00010 && i[21:12] == 10'b1010011111 && i[11:4] == 8'h00)
	begin
		u.use_regs = mask_of(i[3:0]);
		u.def_flags = 1'b1;
	end
	else if (i[27:26] == 2'b00 && i[24:23] == 2'b10 && i[21:12] == 10'b1010001111)
	begin
		u.use_regs = i[25] ? '0 : mask_of(i[3:0]);
		u.def_flags = 1'b1;
	end
	else if (i[27:23] == 5'b00010 && i[21:20] == 2'b00 && i[11:4] == 8'h09)
	begin
		u.use_regs = mask_of(i[19:16]) | mask_of(i[3:0]);
		u.def_regs = mask_of(i[15:12]);
	end
	else if (i[27:4] == 24'h12FFF1)
		u.use_regs = mask_of(i[3:0]);
	else if (i[27:25] == 3'b000 && i[7] && i[4] && (i[22] || i[11:8] == 4'h0))
	begin
		// Halfword transfer, register offset only when bit 22 is clear
		u.use_regs = mask_of(i[19:16]) | (i[22] ? '0 : mask_of(i[3:0]))
			| (i[20] ? '0 : mask_of(i[15:12]));
		u.def_regs = i[20] ? mask_of(i[15:12]) : '0;
	end
	else if (i[27:26] == 2'b00)
	begin
		if (!i[25])
		begin
			u.use_regs = mask_of(i[3:0]) | (i[4] ? mask_of(i[11:8]) : '0);
			// LSL #0 and RRX take the carry in
			if (!i[4] && i[11:7] == 5'd0 && (i[6:5] == 2'b00 || i[6:5] == 2'b11))
				u.use_flags = 1'b1;
		end
		if (i[24:21] != 4'b1101 && i[24:21] != 4'b1111)
			u.use_regs = u.use_regs | mask_of(i[19:16]);
		u.def_flags = i[20];
		// TST, TEQ, CMP and CMN leave Rd alone
		if (i[24:23] != 2'b10)
			u.def_regs = mask_of(i[15:12]);
	end
	else if (i[27:25] == 3'b011 && i[4])
		u = '0;
	else if (i[27:26] == 2'b01)
	begin
		u.use_regs = mask_of(i[19:16]) | (i[25] ? mask_of(i[3:0]) : '0)
			| (i[20] ? '0 : mask_of(i[15:12]));
		u.def_regs = i[20] ? mask_of(i[15:12]) : '0;
	end
	else if (i[27:25] == 3'b100)
	begin
		u.use_regs = mask_of(i[19:16]) | (i[20] ? '0 : list);
		u.def_regs = (i[21] ? mask_of(i[19:16]) : '0) | (i[20] ? list : '0);
		u.def_flags = i[22];
	end
	else if (i[27:25] == 3'b101)
		u.def_regs = i[24] ? mask_of(4'd14) : '0;
	else if (i[27:25] == 3'b110)
	begin
		u.use_regs = mask_of(i[19:16]);
		u.def_regs = i[21] ? mask_of(i[19:16]) : '0;
	end
	else if (i[27:24] == 4'b1110 && i[4])
	begin
		u.use_regs = i[20] ? '0 : mask_of(i[15:12]);
		u.def_regs = i[20] ? mask_of(i[15:12]) : '0;
	end
	return u;
endfunction

function automatic logic cond_passes(input logic [3:0] c, input logic [3:0] nzcv);
	logic n;
	logic z;
	logic cy;
	logic v;
	n = nzcv[3];
	z = nzcv[2];
	cy = nzcv[1];
	v = nzcv[0];
	case (c)
		4'h0: return z;
		4'h1: return !z;
		4'h2: return cy;
		4'h3: return !cy;
		4'h4: return n;
		4'h5: return !n;
		4'h6: return v;
		4'h7: return !v;
		4'h8: return cy && !z;
		4'h9: return !cy || z;
		4'hA: return n == v;
		4'hB: return n != v;
		4'hC: return !z && (n == v);
		4'hD: return z || (n != v);
		4'hE: return 1'b1;
		default: return 1'b0;
	endcase
endfunction

function automatic logic hazard_pending(input usage_t u);
	reg_mask_t busy;
	logic busy_flags;
	busy = '0;
	busy_flags = 1'b0;
	for (int k = 0; k < DEPTH; k++)
	begin
		busy = busy | m_slot[k].def_regs;
		busy_flags = busy_flags | m_slot[k].def_flags;
	end
	return ((u.use_regs & busy) != '0) || (u.use_flags && busy_flags);
endfunction

function automatic logic expected_stall_up(input stage_in_t i, input logic stl, input logic fl);
	return stl || (hazard_pending(expected_usage(i.insn)) && !i.bubble && !fl);
endfunction

task automatic reset_model();
	for (int k = 0; k < DEPTH; k++)
		m_slot[k] = '0;
	m_bubble = 1'b1;
	m_deferred = 1'b0;
endtask

// Moves the model across the coming clock edge
task automatic step_model(input stage_in_t i, input word_t st, input logic stl,
	input logic fl, input logic rst_n);
	usage_t u;
	logic up;
	logic squash;
	u = expected_usage(i.insn);
	up = expected_stall_up(i, stl, fl);
	squash = i.bubble || hazard_pending(u) || !cond_passes(i.insn[31:28], st[31:28]);
	if (!rst_n)
	begin
		reset_model();
	end
	else
	begin
		if (!stl)
		begin
			for (int k = DEPTH - 1; k > 0; k--)
				m_slot[k] = m_slot[k-1];
			m_slot[0].def_regs = squash ? '0 : u.def_regs;
			m_slot[0].def_flags = squash ? 1'b0 : u.def_flags;
			// Old deferred bit still counts on this edge
			m_bubble = squash || fl || m_deferred;
			m_pc = i.pc;
			m_insn = i.insn;
		end
		if (fl && up)
			m_deferred = 1'b1;
		else if (!up)
			m_deferred = 1'b0;
	end
endtask

`endif

// ==== tb_arm_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "arm_consts.svh"

module tb_arm_issue;

	import arm_isa_pkg::*;
	import arm_pipe_pkg::*;

	localparam int DEPTH = 2;
	localparam int RESET_CYCLES = 16;
	localparam int DIRECTED_CYCLES = 300;
	localparam int RANDOM_CYCLES = 2000;
	localparam int MAX_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 500;

	logic       clk;
	logic       Nrst;
	logic       stall;
	logic       flush;
	stage_in_t  issue_in;
	word_t      status;
	stage_out_t issue_out;
	logic       stall_up;
	inflight_t  retire;

	int          errors;
	int          checks;
	int          cycles;
	word_t       pc_count;
	logic [31:0] lcg_state;

	`include "tb_issue_model.svh"

	arm_issue_top #(
		.DEPTH (DEPTH)
	) dut_i (
		.clk      (clk),
		.Nrst     (Nrst),
		.stall    (stall),
		.flush    (flush),
		.in       (issue_in),
		.status   (status),
		.out      (issue_out),
		.stall_up (stall_up),
		.retire   (retire)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ============================================================
	// Helpers
	// ============================================================
	task automatic compare_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0t: %s got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// LCG words built from the upper halves of two states
	function automatic logic [31:0] random_word();
		logic [31:0] hi;
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		hi = {lcg_state[31:16], 16'h0000};
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return hi | {16'h0000, lcg_state[31:16]};
	endfunction

	function automatic word_t dp_imm(input logic [3:0] c, input logic [3:0] op, input logic s,
		input logic [3:0] rn, input logic [3:0] rd, input logic [7:0] imm);
		return {c, 3'b001, op, s, rn, rd, 4'h0, imm};
	endfunction

	function automatic word_t random_insn();
		word_t i;
		logic [31:0] r;
		i = random_word();
		r = random_word();
		// Half the time keep registers within r0..r3 so hazards are frequent
		if (r[0])
			i = i & ~32'h000C_CC0C;
		if (r[3:2] != 2'b00)
			i[31:28] = `COND_AL;
		case (r[7:4])
			4'd0:
			begin
				i[27:22] = 6'b000000;
				i[7:4] = 4'b1001;
			end
			4'd1:
			begin
				i[27:23] = 5'b00010;
				i[21:16] = 6'b001111;
				i[11:0] = 12'h000;
			end
			4'd2:
			begin
				i[27:23] = 5'b00010;
				i[21:12] = 10'b1010011111;
				i[11:4] = 8'h00;
			end
			4'd3:
			begin
				i[27:26] = 2'b00;
				i[24:23] = 2'b10;
				i[21:12] = 10'b1010001111;
			end
			4'd4:
			begin
				i[27:23] = 5'b00010;
				i[21:20] = 2'b00;
				i[11:4] = 8'h09;
			end
			4'd5: i[27:4] = 24'h12FFF1;
			4'd6, 4'd7:
			begin
				i[27:25] = 3'b000;
				i[7] = 1'b1;
				i[4] = 1'b1;
			end
			4'd8:
			begin
				i[27:25] = 3'b011;
				i[4] = 1'b1;
			end
			default:
			begin
				// Raw word whose class follows from bits 27:25
			end
		endcase
		return i;
	endfunction

	// Presents one instruction and holds it until it is accepted
	task automatic send(input word_t insn, output int held);
		issue_in <= '{bubble: 1'b0, pc: pc_count, insn: insn};
		pc_count = pc_count + 4;
		held = 0;
		@(negedge clk);
		while (stall_up)
		begin
			held++;
			@(negedge clk);
		end
		@(posedge clk);
	endtask

	task automatic idle(input int n);
		issue_in.bubble <= 1'b1;
		repeat (n) @(posedge clk);
	endtask

	// Bubble flag of the instruction accepted on the last edge
	task automatic expect_out_bubble(input logic exp, input string what);
		issue_in.bubble <= 1'b1;
		@(negedge clk);
		compare_value(what, issue_out.bubble, exp);
		@(posedge clk);
	endtask

	// ============================================================
	// Compare process checks every cycle against the model
	// ============================================================
	always @(negedge clk)
	begin
		compare_value("stall_up", stall_up, expected_stall_up(issue_in, stall, flush));
		compare_value("out.bubble", issue_out.bubble, m_bubble);
		if (!m_bubble)
		begin
			compare_value("out.pc", issue_out.pc, m_pc);
			compare_value("out.insn", issue_out.insn, m_insn);
		end
		compare_value("retire.def_regs", retire.def_regs, m_slot[DEPTH-1].def_regs);
		compare_value("retire.def_flags", retire.def_flags, m_slot[DEPTH-1].def_flags);
		step_model(issue_in, status, stall, flush, Nrst);
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Something failed");
			$finish;
		end
	end

	// ============================================================
	// Stimulus
	// ============================================================
	initial
	begin
		int held;
		logic hold;
		logic [31:0] r;
		word_t hold_insn;
		word_t hold_pc;
		inflight_t held_ret;
		errors = 0;
		checks = 0;
		cycles = 0;
		pc_count = 32'h0000_1000;
		lcg_state = 32'hb118;
		Nrst = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		status = '0;
		issue_in = '{bubble: 1'b1, pc: '0, insn: '0};
		reset_model();
		repeat (RESET_CYCLES - 1) @(posedge clk);
		@(negedge clk);
		compare_value("reset out.bubble", issue_out.bubble, 1'b1);
		compare_value("reset stall_up", stall_up, 1'b0);
		compare_value("reset retire", retire, '0);
		@(posedge clk);
		Nrst <= 1'b1;
		idle(3);

		// Read-after-write on r3 back to back and with one insn between
		send(dp_imm(`COND_AL, `ALU_MOV, 1'b0, 4'd0, 4'd3, 8'd1), held);
		send(dp_imm(`COND_AL, `ALU_ADD, 1'b0, 4'd3, 4'd4, 8'd1), held);
		compare_value("back-to-back stall cycles", held, 2);
		idle(3);
		send(dp_imm(`COND_AL, `ALU_MOV, 1'b0, 4'd0, 4'd3, 8'd1), held);
		send(dp_imm(`COND_AL, `ALU_MOV, 1'b0, 4'd0, 4'd5, 8'd2), held);
		send(dp_imm(`COND_AL, `ALU_ADD, 1'b0, 4'd3, 4'd4, 8'd1), held);
		compare_value("spaced stall cycles", held, 1);
		idle(3);
		send(dp_imm(`COND_AL, `ALU_CMP, 1'b1, 4'd1, 4'd0, 8'd0), held);
		send(dp_imm(`COND_EQ, `ALU_ADD, 1'b0, 4'd6, 4'd6, 8'd1), held);
		compare_value("flag stall cycles", held, 2);
		idle(3);

		// Condition codes with Z clear
		send(dp_imm(`COND_EQ, `ALU_MOV, 1'b0, 4'd0, 4'd3, 8'd7), held);
		expect_out_bubble(1'b1, "failed EQ bubble");
		send(dp_imm(`COND_AL, `ALU_ADD, 1'b0, 4'd3, 4'd4, 8'd1), held);
		compare_value("reader after failed EQ", held, 0);
		expect_out_bubble(1'b0, "AL issues");
		send(dp_imm(`COND_NV, `ALU_MOV, 1'b0, 4'd0, 4'd7, 8'd1), held);
		expect_out_bubble(1'b1, "NV bubble");
		idle(3);

		// Plain flush followed by a flush while the stage is held
		flush <= 1'b1;
		send(dp_imm(`COND_AL, `ALU_MOV, 1'b0, 4'd0, 4'd8, 8'd1), held);
		flush <= 1'b0;
		expect_out_bubble(1'b1, "flushed insn");
		send(dp_imm(`COND_AL, `ALU_MOV, 1'b0, 4'd0, 4'd3, 8'd1), held);
		issue_in.bubble <= 1'b1;
		stall <= 1'b1;
		flush <= 1'b1;
		@(posedge clk);
		stall <= 1'b0;
		flush <= 1'b0;
		send(dp_imm(`COND_AL, `ALU_ADD, 1'b0, 4'd3, 4'd4, 8'd1), held);
		compare_value("stall after held edge", held, 2);
		expect_out_bubble(1'b1, "deferred flush");
		send(dp_imm(`COND_AL, `ALU_MOV, 1'b0, 4'd0, 4'd9, 8'd1), held);
		expect_out_bubble(1'b0, "after deferred flush");
		idle(3);

		// External stall freezes the stage
		send(dp_imm(`COND_AL, `ALU_MOV, 1'b0, 4'd0, 4'd10, 8'd5), held);
		hold_insn = dp_imm(`COND_AL, `ALU_MOV, 1'b0, 4'd0, 4'd11, 8'd6);
		hold_pc = pc_count;
		send(hold_insn, held);
		// The r10 write sits in the last slot when the stall starts
		held_ret = '0;
		held_ret.def_regs[10] = 1'b1;
		issue_in.bubble <= 1'b1;
		stall <= 1'b1;
		repeat (4)
		begin
			@(negedge clk);
			compare_value("stall_up while held", stall_up, 1'b1);
			compare_value("out.bubble while held", issue_out.bubble, 1'b0);
			compare_value("out.pc while held", issue_out.pc, hold_pc);
			compare_value("out.insn while held", issue_out.insn, hold_insn);
			compare_value("retire while held", retire, held_ret);
		end
		@(posedge clk);
		stall <= 1'b0;
		idle(3);

		// Random mixed stream
		for (int n = 0; n < RANDOM_CYCLES; n++)
		begin
			@(negedge clk);
			hold = stall_up;
			@(posedge clk);
			r = random_word();
			if (!hold)
			begin
				issue_in <= '{bubble: (r[2:0] == 3'd0), pc: pc_count, insn: random_insn()};
				pc_count = pc_count + 4;
			end
			stall <= (r[6:4] == 3'd0);
			flush <= (r[11:8] == 4'd0);
			status <= {r[31:28], 28'h0};
		end
		stall <= 1'b0;
		flush <= 1'b0;
		idle(4);

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
arm_isa_pkg.sv
arm_pipe_pkg.sv
reg_usage_decode.sv
issue_ctrl.sv
inflight_slot.sv
hazard_detect.sv
arm_issue_top.sv
tb_arm_issue.sv

// ==== Bender.yml ====
package:
  name: arm_issue

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - arm_isa_pkg.sv
      - arm_pipe_pkg.sv
      - reg_usage_decode.sv
      - issue_ctrl.sv
      - inflight_slot.sv
      - hazard_detect.sv
      - arm_issue_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_arm_issue.sv
